// ==== axi_wb_bridge/axi_wb_bridge.sv ====
/*
 * Single-beat AXI4 slave to classic Wishbone master.
 * One transfer in flight, writes win over reads, err maps to DECERR.
 */
`timescale 1ns/1ps

module axi_wb_bridge
	import axi_pkg::*;
	import wb_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,

	input  axi_aw_t aw,
	input  logic    aw_valid,
	output logic    aw_ready,
	input  axi_w_t  w,
	input  logic    w_valid,
	output logic    w_ready,
	output axi_b_t  b,
	output logic    b_valid,
	input  logic    b_ready,
	input  axi_ar_t ar,
	input  logic    ar_valid,
	output logic    ar_ready,
	output axi_r_t  r,
	output logic    r_valid,
	input  logic    r_ready,

	output wb_req_t wb_req,
	input  wb_rsp_t wb_rsp
);

	typedef enum logic [2:0] {
		st_idle,
		st_wr_cyc,
		st_rd_cyc,
		st_wr_rsp,
		st_rd_rsp
	} state_e;

	state_e                  state_q;
	logic                    wr_take;
	logic                    rd_take;
	logic                    in_cyc;
	logic                    wb_done;
	logic [axi_id_w-1:0]     id_q;
	logic [axi_addr_w-1:0]   adr_q;
	logic [axi_data_w-1:0]   dat_q;   // write data, then read data
	logic [axi_data_w/8-1:0] sel_q;
	axi_resp_e               resp_q;

	assign wr_take = (state_q == st_idle) && aw_valid && w_valid;
	assign rd_take = (state_q == st_idle) && ar_valid && !(aw_valid && w_valid);
	assign in_cyc  = (state_q == st_wr_cyc) || (state_q == st_rd_cyc);
	assign wb_done = in_cyc && (wb_rsp.ack || wb_rsp.err);

	assign aw_ready = wr_take; // aw and w taken together
	assign w_ready  = wr_take;
	assign ar_ready = rd_take;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= st_idle;
		end else begin
			case (state_q)
				st_idle: begin
					if (wr_take) begin
						state_q <= st_wr_cyc;
					end else if (rd_take) begin
						state_q <= st_rd_cyc;
					end
				end
				st_wr_cyc: begin
					if (wb_done) begin
						state_q <= st_wr_rsp;
					end
				end
				st_rd_cyc: begin
					if (wb_done) begin
						state_q <= st_rd_rsp;
					end
				end
				st_wr_rsp: begin
					if (b_ready) begin
						state_q <= st_idle;
					end
				end
				st_rd_rsp: begin
					if (r_ready) begin
						state_q <= st_idle;
					end
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_take) begin
			id_q  <= aw.id;
			adr_q <= aw.addr;
			dat_q <= w.data;
			sel_q <= w.strb;
		end else if (rd_take) begin
			id_q  <= ar.id;
			adr_q <= ar.addr;
			sel_q <= '1; // reads fetch the whole word
		end
		if (wb_done) begin
			if (wb_rsp.err) begin
				resp_q <= axi_decerr;
			end else begin
				resp_q <= axi_okay;
			end
			if (state_q == st_rd_cyc) begin
				dat_q <= wb_rsp.dat;
			end
		end
	end

	assign wb_req.cyc = in_cyc;
	assign wb_req.stb = in_cyc;
	assign wb_req.we  = (state_q == st_wr_cyc);
	assign wb_req.adr = adr_q;
	assign wb_req.dat = dat_q;
	assign wb_req.sel = sel_q;

	assign b_valid = (state_q == st_wr_rsp);
	assign b.id    = id_q;
	assign b.resp  = resp_q;

	assign r_valid = (state_q == st_rd_rsp);
	assign r.id    = id_q;
	assign r.data  = dat_q;
	assign r.resp  = resp_q;

endmodule

// ==== build.f ====
common/axi_pkg.sv
common/wb_pkg.sv
axi_wb_bridge/axi_wb_bridge.sv
wb_interconnect/wb_interconnect_2x2.sv
hdl/wb_sram.sv
hdl/axi_wb_subsys.sv
verif/axi_wb_subsys_sva.sv
verif/axi_wb_subsys_tb.sv

// ==== common/axi_pkg.sv ====
/*
 * AXI4 bus widths, the response encoding and the payload structs
 * of the five channels, single-beat transfers only
 */
package axi_pkg;

	localparam int axi_addr_w = 32;
	localparam int axi_data_w = 32;
	localparam int axi_id_w   = 6;

	typedef enum logic [1:0] {
		axi_okay   = 2'b00,
		axi_slverr = 2'b10,
		axi_decerr = 2'b11
	} axi_resp_e;

	typedef struct packed {
		logic [axi_id_w-1:0]   id;
		logic [axi_addr_w-1:0] addr;
	} axi_aw_t;

	typedef struct packed {
		logic [axi_data_w-1:0]   data;
		logic [axi_data_w/8-1:0] strb; // one bit per byte lane
	} axi_w_t;

	typedef struct packed {
		logic [axi_id_w-1:0] id;
		axi_resp_e           resp;
	} axi_b_t;

	typedef struct packed {
		logic [axi_id_w-1:0]   id;
		logic [axi_addr_w-1:0] addr;
	} axi_ar_t;

	typedef struct packed {
		logic [axi_id_w-1:0]   id;
		logic [axi_data_w-1:0] data;
		axi_resp_e             resp;
	} axi_r_t;

endpackage

// ==== common/wb_pkg.sv ====
/*
 * Wishbone classic bus widths and the request / response structs
 * shared by masters, the interconnect and the slaves
 */
package wb_pkg;

	localparam int wb_addr_w = 32;
	localparam int wb_data_w = 32;

	// master to slave
	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [wb_addr_w-1:0]   adr;   // byte address
		logic [wb_data_w-1:0]   dat;
		logic [wb_data_w/8-1:0] sel;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic                 ack;
		logic                 err;
		logic [wb_data_w-1:0] dat;
	} wb_rsp_t;

endpackage

// ==== hdl/axi_wb_subsys.sv ====
/*
 * Subsystem top: AXI4 port through the bridge, external Wishbone master,
 * 2x2 interconnect and two SRAMs behind it
 */
`timescale 1ns/1ps

module axi_wb_subsys
	import axi_pkg::*;
	import wb_pkg::*;
#(
	parameter logic [wb_addr_w-1:0] s0_base       = 32'h0000_1000,
	parameter logic [wb_addr_w-1:0] s0_limit      = 32'h0000_1fff,
	parameter logic [wb_addr_w-1:0] s1_base       = 32'h0000_2000,
	parameter logic [wb_addr_w-1:0] s1_limit      = 32'h0000_2fff,
	parameter int                   mem_addr_bits = 10
) (
	input  logic    clk,
	input  logic    arst_n,

	input  axi_aw_t aw,
	input  logic    aw_valid,
	output logic    aw_ready,
	input  axi_w_t  w,
	input  logic    w_valid,
	output logic    w_ready,
	output axi_b_t  b,
	output logic    b_valid,
	input  logic    b_ready,
	input  axi_ar_t ar,
	input  logic    ar_valid,
	output logic    ar_ready,
	output axi_r_t  r,
	output logic    r_valid,
	input  logic    r_ready,

	input  wb_req_t wb_req,
	output wb_rsp_t wb_rsp
);

	wb_req_t m0_req;
	wb_rsp_t m0_rsp;
	wb_req_t s0_req;
	wb_rsp_t s0_rsp;
	wb_req_t s1_req;
	wb_rsp_t s1_rsp;

	axi_wb_bridge i_axi_wb_bridge (
		.clk      (clk),
		.arst_n   (arst_n),
		.aw       (aw),
		.aw_valid (aw_valid),
		.aw_ready (aw_ready),
		.w        (w),
		.w_valid  (w_valid),
		.w_ready  (w_ready),
		.b        (b),
		.b_valid  (b_valid),
		.b_ready  (b_ready),
		.ar       (ar),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.r        (r),
		.r_valid  (r_valid),
		.r_ready  (r_ready),
		.wb_req   (m0_req),
		.wb_rsp   (m0_rsp)
	);

	wb_interconnect_2x2 #(
		.s0_base  (s0_base),
		.s0_limit (s0_limit),
		.s1_base  (s1_base),
		.s1_limit (s1_limit)
	) i_wb_interconnect_2x2 (
		.clk    (clk),
		.arst_n (arst_n),
		.m0_req (m0_req),
		.m0_rsp (m0_rsp),
		.m1_req (wb_req), // external master port
		.m1_rsp (wb_rsp),
		.s0_req (s0_req),
		.s0_rsp (s0_rsp),
		.s1_req (s1_req),
		.s1_rsp (s1_rsp)
	);

	wb_sram #(
		.mem_addr_bits (mem_addr_bits)
	) i_wb_sram_0 (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (s0_req),
		.rsp    (s0_rsp)
	);

	wb_sram #(
		.mem_addr_bits (mem_addr_bits)
	) i_wb_sram_1 (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (s1_req),
		.rsp    (s1_rsp)
	);

endmodule

// ==== hdl/wb_sram.sv ====
/*
 * Wishbone slave memory, byte selects on writes,
 * registered single-cycle acknowledge with read data
 */
`timescale 1ns/1ps

module wb_sram
	import wb_pkg::*;
#(
	parameter int mem_addr_bits = 10
) (
	input  logic    clk,
	input  logic    arst_n,
	input  wb_req_t req,
	output wb_rsp_t rsp
);

	localparam int off_w = $clog2(wb_data_w / 8);

	logic [wb_data_w-1:0]     mem [2**mem_addr_bits];
	logic [mem_addr_bits-1:0] idx;
	logic                     hit;
	logic                     ack_q;
	logic [wb_data_w-1:0]     rdata_q;

	assign idx = req.adr[mem_addr_bits+off_w-1:off_w]; // word index
	assign hit = req.cyc && req.stb && !ack_q;        // no second ack for the same stb

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= hit;
		end
	end

	always_ff @(posedge clk) begin
		if (hit) begin
			if (req.we) begin
				for (int i = 0; i < wb_data_w / 8; i++) begin
					if (req.sel[i]) begin
						mem[idx][8*i +: 8] <= req.dat[8*i +: 8];
					end
				end
			end
			rdata_q <= mem[idx];
		end
	end

	assign rsp.ack = ack_q;
	assign rsp.err = 1'b0;
	assign rsp.dat = rdata_q;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module axi_wb_subsys_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vaxi_wb_subsys_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Test passed"; then
	exit 0
else
	exit 1
fi

// ==== verif/axi_wb_subsys_sva.sv ====
/*
 * Protocol assertions bound to the subsystem top: AXI response hold,
 * Wishbone strobe and acknowledge rules, idle outputs in reset
 */
`timescale 1ns/1ps

module axi_wb_subsys_sva
	import axi_pkg::*;
	import wb_pkg::*;
(
	input logic    clk,
	input logic    arst_n,
	input axi_b_t  b,
	input logic    b_valid,
	input logic    b_ready,
	input axi_r_t  r,
	input logic    r_valid,
	input logic    r_ready,
	input wb_req_t m0_req,
	input wb_rsp_t m0_rsp,
	input wb_req_t wb_req,
	input wb_rsp_t wb_rsp,
	input wb_req_t s0_req,
	input wb_rsp_t s0_rsp,
	input wb_req_t s1_req,
	input wb_rsp_t s1_rsp
);

	b_hold: assert property (@(posedge clk) disable iff (!arst_n)
		b_valid && !b_ready |=> b_valid && $stable(b))
		else $error("b dropped or changed under back-pressure");

	r_hold: assert property (@(posedge clk) disable iff (!arst_n)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else $error("r dropped or changed under back-pressure");

	m0_stb_hold: assert property (@(posedge clk) disable iff (!arst_n)
		m0_req.stb && !m0_rsp.ack && !m0_rsp.err |=> m0_req.stb && $stable(m0_req))
		else $error("bridge request changed before ack or err");

	s0_stb_hold: assert property (@(posedge clk) disable iff (!arst_n)
		s0_req.stb && !s0_rsp.ack |=> s0_req.stb)
		else $error("slave 0 strobe dropped before ack");

	s1_stb_hold: assert property (@(posedge clk) disable iff (!arst_n)
		s1_req.stb && !s1_rsp.ack |=> s1_req.stb)
		else $error("slave 1 strobe dropped before ack");

	ack_err_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(m0_rsp.ack && m0_rsp.err) && !(wb_rsp.ack && wb_rsp.err))
		else $error("ack and err high together");

	rsp_needs_stb: assert property (@(posedge clk) disable iff (!arst_n)
		(!(m0_rsp.ack || m0_rsp.err) || m0_req.stb)
		&& (!(wb_rsp.ack || wb_rsp.err) || wb_req.stb)
		&& (!s0_rsp.ack || s0_req.stb) && (!s1_rsp.ack || s1_req.stb))
		else $error("ack or err without stb");

	reset_idle: assert property (@(posedge clk)
		!arst_n |-> !m0_req.cyc && !s0_req.cyc && !s1_req.cyc && !b_valid && !r_valid)
		else $error("cyc or valid high during reset");

endmodule

// ==== verif/axi_wb_subsys_tb.sv ====
/*
 * Testbench for the AXI4 / Wishbone subsystem: clock and reset,
 * AXI and Wishbone drivers, reference memory model, checks, watchdog
 */
`timescale 1ns/1ps

module axi_wb_subsys_tb
	import axi_pkg::*;
	import wb_pkg::*;
();

	localparam logic [31:0] s0_base       = 32'h0000_1000;
	localparam logic [31:0] s0_limit      = 32'h0000_1fff;
	localparam logic [31:0] s1_base       = 32'h0000_2000;
	localparam logic [31:0] s1_limit      = 32'h0000_2fff;
	localparam int          mem_addr_bits = 10;
	localparam int          words         = 2**mem_addr_bits;
	localparam int          n_basic       = 40;
	localparam int          n_merge       = 20;
	localparam int          n_unmapped    = 10;
	localparam int          n_conc        = 20;
	localparam int          n_stall       = 20;
	// clear of both memories, then transfers per loop pass of each test
	localparam int          n_transfers   = 2 * words + 2 * n_basic + 5 * n_merge
		+ 6 * n_unmapped + 6 * n_conc + 2 * n_stall;
	localparam int          timeout_ns    = (n_transfers * 40 + 1000) * 40;

	logic        clk = 1'b0;
	logic        arst_n;
	axi_aw_t     aw;
	logic        aw_valid;
	logic        aw_ready;
	axi_w_t      w;
	logic        w_valid;
	logic        w_ready;
	axi_b_t      b;
	logic        b_valid;
	logic        b_ready;
	axi_ar_t     ar;
	logic        ar_valid;
	logic        ar_ready;
	axi_r_t      r;
	logic        r_valid;
	logic        r_ready;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	integer      seed;
	int          checks;
	int          errors;
	logic        stall_en;
	time         b_time;
	time         r_time;
	logic [31:0] ref_mem [logic [31:0]]; // keyed by word address

	always #20 clk = ~clk;

	axi_wb_subsys #(
		.s0_base       (s0_base),
		.s0_limit      (s0_limit),
		.s1_base       (s1_base),
		.s1_limit      (s1_limit),
		.mem_addr_bits (mem_addr_bits)
	) i_axi_wb_subsys (
		.clk      (clk),
		.arst_n   (arst_n),
		.aw       (aw),
		.aw_valid (aw_valid),
		.aw_ready (aw_ready),
		.w        (w),
		.w_valid  (w_valid),
		.w_ready  (w_ready),
		.b        (b),
		.b_valid  (b_valid),
		.b_ready  (b_ready),
		.ar       (ar),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.r        (r),
		.r_valid  (r_valid),
		.r_ready  (r_ready),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp)
	);

	bind axi_wb_subsys axi_wb_subsys_sva i_axi_wb_subsys_sva (
		.clk     (clk),
		.arst_n  (arst_n),
		.b       (b),
		.b_valid (b_valid),
		.b_ready (b_ready),
		.r       (r),
		.r_valid (r_valid),
		.r_ready (r_ready),
		.m0_req  (m0_req),
		.m0_rsp  (m0_rsp),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.s0_req  (s0_req),
		.s0_rsp  (s0_rsp),
		.s1_req  (s1_req),
		.s1_rsp  (s1_rsp)
	);

	function automatic logic mapped(logic [31:0] addr);
		return (addr >= s0_base && addr <= s0_limit) || (addr >= s1_base && addr <= s1_limit);
	endfunction

	// byte-select merge into the reference memory
	function automatic void ref_write(logic [31:0] addr, logic [31:0] data, logic [3:0] sel);
		logic [31:0] word;
		if (!mapped(addr)) begin
			return;
		end
		word = ref_mem.exists(addr >> 2) ? ref_mem[addr >> 2] : 32'd0;
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				word[8*i +: 8] = data[8*i +: 8];
			end
		end
		ref_mem[addr >> 2] = word;
	endfunction

	function automatic axi_r_t ref_read(logic [31:0] addr);
		axi_r_t exp;
		exp = '0;
		if (!mapped(addr)) begin
			exp.resp = axi_decerr;
		end else if (ref_mem.exists(addr >> 2)) begin
			exp.data = ref_mem[addr >> 2];
		end
		return exp;
	endfunction

	function automatic logic [31:0] rand_addr();
		logic [31:0] rnd;
		rnd = $random(seed);
		return (rnd[12] ? s1_base : s0_base) + {20'd0, rnd[9:0], 2'b00};
	endfunction

	function automatic logic [31:0] rand_unmapped();
		logic [31:0] rnd;
		rnd      = $random(seed);
		rnd[1:0] = 2'b00;
		if (mapped(rnd)) begin
			rnd[31] = 1'b1;
		end
		return rnd;
	endfunction

	task automatic check(string name, logic [31:0] actual, logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %0d ns %s: actual %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic axi_write(logic [axi_id_w-1:0] tid, logic [31:0] addr, logic [31:0] data,
			logic [3:0] strb);
		logic   done;
		axi_b_t got;
		axi_r_t exp;
		aw       = '{id: tid, addr: addr};
		w        = '{data: data, strb: strb};
		aw_valid = 1'b1;
		w_valid  = 1'b1;
		do begin
			@(negedge clk);
			done = aw_ready && w_ready;
			@(posedge clk);
		end while (!done);
		#2;
		aw_valid = 1'b0;
		w_valid  = 1'b0;
		do begin
			@(negedge clk);
			done = b_valid && b_ready;
			got  = b;
			@(posedge clk);
		end while (!done);
		b_time = $time;
		exp    = ref_read(addr);
		check("b.id", 32'(got.id), 32'(tid));
		check("b.resp", 32'(got.resp), 32'(exp.resp));
		ref_write(addr, data, strb);
		#2;
	endtask

	task automatic axi_read(logic [axi_id_w-1:0] tid, logic [31:0] addr);
		logic   done;
		axi_r_t got;
		axi_r_t exp;
		ar       = '{id: tid, addr: addr};
		ar_valid = 1'b1;
		do begin
			@(negedge clk);
			done = ar_ready;
			@(posedge clk);
		end while (!done);
		#2;
		ar_valid = 1'b0;
		do begin
			@(negedge clk);
			done = r_valid && r_ready;
			got  = r;
			@(posedge clk);
		end while (!done);
		r_time = $time;
		exp    = ref_read(addr);
		check("r.id", 32'(got.id), 32'(tid));
		check("r.resp", 32'(got.resp), 32'(exp.resp));
		if (exp.resp == axi_okay) begin
			check("r.data", got.data, exp.data);
		end
		#2;
	endtask

	// one classic cycle on the external port, then one idle cycle
	task automatic wb_access(logic we, logic [31:0] addr, logic [31:0] data, logic [3:0] sel);
		logic        done;
		logic        err;
		logic [31:0] rdat;
		axi_r_t      exp;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, dat: data, sel: sel};
		do begin
			@(negedge clk);
			done = wb_rsp.ack || wb_rsp.err;
			err  = wb_rsp.err;
			rdat = wb_rsp.dat;
			@(posedge clk);
		end while (!done);
		#2;
		wb_req = '0;
		exp    = ref_read(addr);
		check("wb_rsp.err", 32'(err), 32'(exp.resp == axi_decerr));
		if (we) begin
			ref_write(addr, data, sel);
		end else if (exp.resp == axi_okay) begin
			check("wb_rsp.dat", rdat, exp.data);
		end
		@(posedge clk);
		#2;
	endtask

	task automatic report(string name, int err_start);
		$display("%s: done, %0d errors", name, errors - err_start);
	endtask

	// b_ready and r_ready go randomly low while stall_en is set
	initial begin
		logic [31:0] rnd;
		logic [1:0]  ready_nxt;
		b_ready = 1'b0;
		r_ready = 1'b0;
		forever begin
			@(negedge clk);
			rnd       = $random(seed);
			ready_nxt = stall_en ? rnd[1:0] : 2'b11;
			@(posedge clk);
			#2;
			b_ready = ready_nxt[0];
			r_ready = ready_nxt[1];
		end
	end

	initial begin
		#(timeout_ns);
		$display("timeout: the transfers did not finish within %0d ns", timeout_ns);
		$display("Test failed");
		$finish;
	end

	initial begin
		logic [31:0] addr;
		logic [31:0] addr2;
		logic [31:0] data;
		logic [31:0] rnd;
		int          err_start;
		seed     = 32'h861f_9a02;
		checks   = 0;
		errors   = 0;
		stall_en = 1'b0;
		arst_n   = 1'b0;
		aw       = '0;
		aw_valid = 1'b0;
		w        = '0;
		w_valid  = 1'b0;
		ar       = '0;
		ar_valid = 1'b0;
		wb_req   = '0;
		repeat (2) @(posedge clk);
		#2;
		arst_n = 1'b1;

		for (int i = 0; i < 2 * words; i++) begin // both windows are contiguous
			wb_access(1'b1, s0_base + 32'(i) * 4, 32'd0, 4'hf);
		end

		err_start = errors;
		for (int i = 0; i < n_basic; i++) begin
			addr = rand_addr();
			data = $random(seed);
			rnd  = $random(seed);
			axi_write(rnd[5:0], addr, data, 4'hf);
			axi_read(rnd[11:6], addr);
		end
		report("test 1 axi write and read", err_start);

		err_start = errors;
		for (int i = 0; i < n_merge; i++) begin
			addr = rand_addr();
			data = $random(seed);
			rnd  = $random(seed);
			axi_write(rnd[5:0], addr, data, 4'hf);
			data = $random(seed);
			axi_write(rnd[11:6], addr, data, rnd[15:12]);
			wb_access(1'b0, addr, 32'd0, 4'hf);
			data = $random(seed);
			wb_access(1'b1, addr, data, rnd[19:16]);
			axi_read(rnd[25:20], addr);
		end
		report("test 2 byte strobes", err_start);

		err_start = errors;
		for (int i = 0; i < n_unmapped; i++) begin
			if (i == 0) begin
				addr = s0_base - 32'd4;
			end else if (i == 1) begin
				addr = s1_limit + 32'd1;
			end else begin
				addr = rand_unmapped();
			end
			data = $random(seed);
			rnd  = $random(seed);
			axi_write(rnd[5:0], addr, data, 4'hf);
			axi_read(rnd[11:6], addr);
			wb_access(1'b1, addr, data, 4'hf);
			wb_access(1'b0, addr, 32'd0, 4'hf);
			// a misrouted write would land on one of these words
			axi_read(rnd[17:12], s0_base + {20'd0, addr[11:0]});
			axi_read(rnd[23:18], s1_base + {20'd0, addr[11:0]});
		end
		report("test 3 unmapped addresses", err_start);

		err_start = errors;
		for (int i = 0; i < n_conc; i++) begin
			addr  = rand_addr();
			addr2 = rand_addr();
			if (addr[31:2] == addr2[31:2]) begin
				addr2 = addr2 ^ 32'h4;
			end
			data = $random(seed);
			rnd  = $random(seed);
			fork
				begin
					axi_write(rnd[5:0], addr, data, 4'hf);
					axi_read(rnd[11:6], addr);
				end
				begin
					wb_access(1'b1, addr2, rnd, 4'hf);
					wb_access(1'b0, addr2, 32'd0, 4'hf);
				end
			join
			axi_read(rnd[17:12], addr2);
			wb_access(1'b0, addr, 32'd0, 4'hf);
		end
		report("test 4 concurrent masters", err_start);

		err_start = errors;
		stall_en  = 1'b1;
		for (int i = 0; i < n_stall; i++) begin
			addr = rand_addr();
			data = $random(seed);
			rnd  = $random(seed);
			fork
				axi_write(rnd[5:0], addr, data, 4'hf);
				axi_read(rnd[11:6], addr); // offered while the write is in flight
			join
			check("r after b", 32'(r_time > b_time), 32'd1);
		end
		stall_en = 1'b0;
		report("test 5 response back-pressure", err_start);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== wb_interconnect/wb_interconnect_2x2.sv ====
/*
 * Two-master, two-slave Wishbone interconnect: round-robin grant held
 * for the whole cycle, base/limit decoding, err for unmapped addresses
 */
`timescale 1ns/1ps

module wb_interconnect_2x2
	import wb_pkg::*;
#(
	parameter logic [wb_addr_w-1:0] s0_base  = 32'h0000_1000,
	parameter logic [wb_addr_w-1:0] s0_limit = 32'h0000_1fff,
	parameter logic [wb_addr_w-1:0] s1_base  = 32'h0000_2000,
	parameter logic [wb_addr_w-1:0] s1_limit = 32'h0000_2fff
) (
	input  logic    clk,
	input  logic    arst_n,
	input  wb_req_t m0_req,
	output wb_rsp_t m0_rsp,
	input  wb_req_t m1_req,
	output wb_rsp_t m1_rsp,
	output wb_req_t s0_req,
	input  wb_rsp_t s0_rsp,
	output wb_req_t s1_req,
	input  wb_rsp_t s1_rsp
);

	logic    gnt_vld_q;
	logic    gnt_q;    // granted master, kept after release for round robin
	logic    pick;
	logic    err_q;
	logic    hit0;
	logic    hit1;
	wb_req_t mreq;
	wb_rsp_t srsp;

	// request towards one slave, address made relative to its window
	function automatic wb_req_t slave_req(wb_req_t req, logic act, logic hit,
			logic [wb_addr_w-1:0] base);
		wb_req_t sreq;
		sreq     = req;
		sreq.adr = req.adr - base;
		sreq.cyc = act && req.cyc && hit;
		sreq.stb = act && req.cyc && req.stb && hit;
		return sreq;
	endfunction

	assign pick = (m0_req.cyc && m1_req.cyc) ? !gnt_q : m1_req.cyc;
	assign mreq = gnt_q ? m1_req : m0_req;
	assign hit0 = (mreq.adr >= s0_base) && (mreq.adr <= s0_limit);
	assign hit1 = (mreq.adr >= s1_base) && (mreq.adr <= s1_limit);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			gnt_vld_q <= 1'b0;
			gnt_q     <= 1'b1; // m0 wins the first tie
			err_q     <= 1'b0;
		end else begin
			if (!gnt_vld_q) begin
				if (m0_req.cyc || m1_req.cyc) begin
					gnt_vld_q <= 1'b1;
					gnt_q     <= pick;
				end
			end else if (!mreq.cyc) begin
				gnt_vld_q <= 1'b0; // master ended its cycle
			end
			// one err pulse per unmapped strobe
			err_q <= gnt_vld_q && mreq.cyc && mreq.stb && !hit0 && !hit1 && !err_q;
		end
	end

	assign s0_req = slave_req(mreq, gnt_vld_q, hit0, s0_base);
	assign s1_req = slave_req(mreq, gnt_vld_q, hit1, s1_base);

	always_comb begin
		if (hit0) begin
			srsp = s0_rsp;
		end else if (hit1) begin
			srsp = s1_rsp;
		end else begin
			srsp     = '0;
			srsp.err = err_q;
		end
		m0_rsp = '0;
		m1_rsp = '0;
		if (gnt_vld_q) begin
			if (gnt_q) begin
				m1_rsp = srsp;
			end else begin
				m0_rsp = srsp;
			end
		end
	end

endmodule
